// ==== cache_wr_pkg.sv ====
package cache_wr_pkg;

   // address and data widths
   localparam int ADDR_W    = 24;  // byte address
   localparam int DATA_W    = 32;  // cache word
   localparam int BE_DATA_W = 64;  // memory beat

   localparam int NBYTES    = DATA_W / 8;
   localparam int BE_NBYTES = BE_DATA_W / 8;
   localparam int NBYTES_W  = $clog2(NBYTES);     // word offset bits
   localparam int BE_OFF_W  = $clog2(BE_NBYTES);  // beat offset bits
   localparam int WORD_SEL_W = BE_OFF_W - NBYTES_W;  // word slot within a beat

   // line geometry
   localparam int LINE_WORDS     = 4;
   localparam int LINE_W         = LINE_WORDS * DATA_W;
   localparam int LINE_OFF_W     = $clog2(LINE_W / 8);
   localparam int BEATS_PER_LINE = LINE_W / BE_DATA_W;
   localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

   localparam int WORD_ADDR_W = ADDR_W - NBYTES_W;    // 22
   localparam int LINE_ADDR_W = ADDR_W - LINE_OFF_W;  // 20

   // payload is sized by the line request, the larger of the two
   localparam int REQ_W      = LINE_ADDR_W + LINE_W;
   localparam int WORD_PAD_W = REQ_W - WORD_ADDR_W - DATA_W - NBYTES;

   // entry kinds
   localparam logic KIND_WORD = 1'b0;
   localparam logic KIND_LINE = 1'b1;

   // AXI write response
   localparam logic [1:0] RESP_OKAY = 2'b00;

   typedef struct packed {
      logic [WORD_PAD_W-1:0]  pad;   // unused upper bits
      logic [WORD_ADDR_W-1:0] addr;  // byte address without low bits
      logic [DATA_W-1:0]      data;
      logic [NBYTES-1:0]      strb;
   } word_req_t;

   typedef struct packed {
      logic [LINE_ADDR_W-1:0] addr;  // line address
      logic [LINE_W-1:0]      data;
   } line_req_t;

   // one stored payload, read as a word or as a line depending on kind
   typedef union packed {
      word_req_t word;
      line_req_t line;
   } req_payload_t;

   typedef struct packed {
      logic         kind;  // 0 word, 1 line
      req_payload_t payload;
   } wr_entry_t;

endpackage

// ==== cache_wr_buffer.sv ====
`timescale 1ns/1ps

module cache_wr_buffer
   import cache_wr_pkg::*;
#(
   parameter int BUF_DEPTH_W = 2
) (
   input  logic      clk_i,
   input  logic      reset,
   input  logic      push_i,
   input  wr_entry_t entry_i,
   input  logic      pop_i,
   output wr_entry_t head_o,
   output logic      full_o,
   output logic      empty_o
);

   localparam int DEPTH = 2 ** BUF_DEPTH_W;

   wr_entry_t mem [DEPTH];  // entry storage, no reset

   logic [BUF_DEPTH_W-1:0] wr_ptr;
   logic [BUF_DEPTH_W-1:0] rd_ptr;
   logic [BUF_DEPTH_W:0]   count;  // one extra bit to tell full from empty

   logic do_push;
   logic do_pop;

   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign full_o  = (count == (BUF_DEPTH_W + 1)'(DEPTH));
   assign empty_o = (count == '0);
   assign head_o  = mem[rd_ptr];  // oldest entry

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= entry_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps around
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   // the request side must respect req_ready
   a_no_push_full : assert property (
      @(posedge clk_i) disable iff (reset) push_i |-> !full_o
   ) else $error("push into full write buffer");

   // controller pops only an entry it has finished
   a_no_pop_empty : assert property (
      @(posedge clk_i) disable iff (reset) pop_i |-> !empty_o
   ) else $error("pop from empty write buffer");

endmodule

// ==== axi_wr_beat_gen.sv ====
`timescale 1ns/1ps

module axi_wr_beat_gen
   import cache_wr_pkg::*;
#(
   parameter int AXI_AW_LEN_W = 8
) (
   input  logic                    clk_i,
   input  logic                    reset,
   input  wr_entry_t               head_i,
   input  logic                    beat_clr_i,
   input  logic                    beat_inc_i,
   output logic                    last_beat_o,
   output logic [ADDR_W-1:0]       axi_awaddr_o,
   output logic [AXI_AW_LEN_W-1:0] axi_awlen_o,
   output logic [BE_DATA_W-1:0]    axi_wdata_o,
   output logic [BE_NBYTES-1:0]    axi_wstrb_o,
   output logic                    axi_wlast_o
);

   logic [BEAT_CNT_W-1:0] beat_cnt;  // beat index within the burst

   word_req_t word_req;
   line_req_t line_req;
   logic      is_line;

   // same payload bits, two views
   assign word_req = head_i.payload.word;
   assign line_req = head_i.payload.line;
   assign is_line  = (head_i.kind == KIND_LINE);

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         beat_cnt <= '0;
      end else if (beat_clr_i) begin
         beat_cnt <= '0;  // new or repeated transaction
      end else if (beat_inc_i) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   always_comb begin
      if (is_line) begin
         // burst aligned to the line, low half first
         axi_awaddr_o = {line_req.addr, {LINE_OFF_W{1'b0}}};
         axi_awlen_o  = AXI_AW_LEN_W'(BEATS_PER_LINE - 1);
         axi_wdata_o  = line_req.data[beat_cnt*BE_DATA_W +: BE_DATA_W];
         axi_wstrb_o  = {BE_NBYTES{1'b1}};
         last_beat_o  = (beat_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1));
      end else begin
         // single beat, word replicated over the beat
         axi_awaddr_o = {word_req.addr[WORD_ADDR_W-1:WORD_SEL_W], {BE_OFF_W{1'b0}}};
         axi_awlen_o  = '0;
         axi_wdata_o  = {(BE_DATA_W / DATA_W){word_req.data}};
         axi_wstrb_o  = BE_NBYTES'(word_req.strb)
                        << (word_req.addr[WORD_SEL_W-1:0] * NBYTES);  // pick word slot
         last_beat_o  = 1'b1;
      end
   end

   // final beat once the counter reaches the burst length
   assign axi_wlast_o = (AXI_AW_LEN_W'(beat_cnt) == axi_awlen_o);

   // controller must stop stepping at the final beat
   a_cnt_no_overrun : assert property (
      @(posedge clk_i) disable iff (reset) beat_inc_i |-> !last_beat_o
   ) else $error("beat counter stepped past last beat");

endmodule

// ==== axi_wr_ctrl.sv ====
`timescale 1ns/1ps

module axi_wr_ctrl
   import cache_wr_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset,
   input  logic       empty_i,
   input  logic       last_beat_i,
   output logic       pop_o,
   output logic       beat_clr_o,
   output logic       beat_inc_o,
   output logic       idle_o,
   output logic       axi_awvalid_o,
   input  logic       axi_awready_i,
   output logic       axi_wvalid_o,
   input  logic       axi_wready_i,
   input  logic       axi_wlast_i,
   input  logic       axi_bvalid_i,
   input  logic [1:0] axi_bresp_i,
   output logic       axi_bready_o
);

   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_ADDR   = 2'd1;
   localparam logic [1:0] ST_WRITE  = 2'd2;
   localparam logic [1:0] ST_VERIFY = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;

   logic aw_hs;
   logic w_hs;
   logic b_hs;
   logic b_okay;

   assign aw_hs  = axi_awvalid_o & axi_awready_i;
   assign w_hs   = axi_wvalid_o & axi_wready_i;
   assign b_hs   = axi_bvalid_i & axi_bready_o;
   assign b_okay = (axi_bresp_i == RESP_OKAY);

   // after a pop the address state may find the buffer drained
   assign axi_awvalid_o = (state == ST_ADDR) & ~empty_i;
   assign axi_wvalid_o  = (state == ST_WRITE);
   assign axi_bready_o  = (state == ST_VERIFY);

   assign pop_o      = b_hs & b_okay;         // entry done
   assign beat_clr_o = b_hs;                  // fresh count for next or retried entry
   assign beat_inc_o = w_hs & ~last_beat_i;   // step until the final beat
   assign idle_o     = (state == ST_IDLE) & empty_i;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (!empty_i) begin
               state_nxt = ST_ADDR;
            end
         end
         ST_ADDR: begin
            if (empty_i) begin
               state_nxt = ST_IDLE;  // nothing left after the last pop
            end else if (aw_hs) begin
               state_nxt = ST_WRITE;
            end
         end
         ST_WRITE: begin
            if (w_hs && last_beat_i) begin
               state_nxt = ST_VERIFY;
            end
         end
         default: begin  // verify
            if (b_hs) begin
               // okay moves on to the next entry, error repeats this one
               state_nxt = ST_ADDR;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // AXI rule: address valid is held until accepted
   a_awvalid_stable : assert property (
      @(posedge clk_i) disable iff (reset)
      axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o
   ) else $error("awvalid dropped before awready");

   // wlast from the beat generator must agree with the counter
   a_wlast_match : assert property (
      @(posedge clk_i) disable iff (reset)
      w_hs |-> (axi_wlast_i == last_beat_i)
   ) else $error("wlast does not match last beat");

endmodule

// ==== cache_wr_path.sv ====
`timescale 1ns/1ps

module cache_wr_path
   import cache_wr_pkg::*;
#(
   parameter int BUF_DEPTH_W  = 2,
   parameter int AXI_AW_LEN_W = 8
) (
   input  logic                    clk_i,
   input  logic                    reset,
   // request from the cache core
   input  logic                    req_valid_i,
   input  logic                    req_kind_i,
   input  logic [ADDR_W-1:0]       req_addr_i,
   input  logic [LINE_W-1:0]       req_wdata_i,
   input  logic [NBYTES-1:0]       req_wstrb_i,
   output logic                    req_ready_o,
   output logic                    idle_o,
   // AXI write channel
   output logic [ADDR_W-1:0]       axi_awaddr_o,
   output logic [AXI_AW_LEN_W-1:0] axi_awlen_o,
   output logic                    axi_awvalid_o,
   input  logic                    axi_awready_i,
   output logic [BE_DATA_W-1:0]    axi_wdata_o,
   output logic [BE_NBYTES-1:0]    axi_wstrb_o,
   output logic                    axi_wlast_o,
   output logic                    axi_wvalid_o,
   input  logic                    axi_wready_i,
   input  logic                    axi_bvalid_i,
   input  logic [1:0]              axi_bresp_i,
   output logic                    axi_bready_o
);

   wr_entry_t new_entry;
   wr_entry_t head;
   logic      buf_full;
   logic      buf_empty;
   logic      push;
   logic      pop;
   logic      beat_clr;
   logic      beat_inc;
   logic      last_beat;

   assign req_ready_o = ~buf_full;
   assign push        = req_valid_i & req_ready_o;

   always_comb begin
      new_entry      = '0;
      new_entry.kind = req_kind_i;
      if (req_kind_i == KIND_LINE) begin
         new_entry.payload.line.addr = req_addr_i[ADDR_W-1:LINE_OFF_W];
         new_entry.payload.line.data = req_wdata_i;
      end else begin
         new_entry.payload.word.addr = req_addr_i[ADDR_W-1:NBYTES_W];
         new_entry.payload.word.data = req_wdata_i[DATA_W-1:0];  // low word only
         new_entry.payload.word.strb = req_wstrb_i;
      end
   end

   cache_wr_buffer #(
      .BUF_DEPTH_W(BUF_DEPTH_W)
   ) wr_buffer_i (
      .clk_i  (clk_i),
      .reset  (reset),
      .push_i (push),
      .entry_i(new_entry),
      .pop_i  (pop),
      .head_o (head),
      .full_o (buf_full),
      .empty_o(buf_empty)
   );

   axi_wr_ctrl wr_ctrl_i (
      .clk_i        (clk_i),
      .reset        (reset),
      .empty_i      (buf_empty),
      .last_beat_i  (last_beat),
      .pop_o        (pop),
      .beat_clr_o   (beat_clr),
      .beat_inc_o   (beat_inc),
      .idle_o       (idle_o),
      .axi_awvalid_o(axi_awvalid_o),
      .axi_awready_i(axi_awready_i),
      .axi_wvalid_o (axi_wvalid_o),
      .axi_wready_i (axi_wready_i),
      .axi_wlast_i  (axi_wlast_o),
      .axi_bvalid_i (axi_bvalid_i),
      .axi_bresp_i  (axi_bresp_i),
      .axi_bready_o (axi_bready_o)
   );

   axi_wr_beat_gen #(
      .AXI_AW_LEN_W(AXI_AW_LEN_W)
   ) beat_gen_i (
      .clk_i       (clk_i),
      .reset       (reset),
      .head_i      (head),
      .beat_clr_i  (beat_clr),
      .beat_inc_i  (beat_inc),
      .last_beat_o (last_beat),
      .axi_awaddr_o(axi_awaddr_o),
      .axi_awlen_o (axi_awlen_o),
      .axi_wdata_o (axi_wdata_o),
      .axi_wstrb_o (axi_wstrb_o),
      .axi_wlast_o (axi_wlast_o)
   );

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem
   import cache_wr_pkg::*;
#(
   parameter int          MEM_BYTES = 1024,
   parameter int          LEN_W     = 8,
   parameter int          ERR_EVERY = 5,
   parameter logic [31:0] SEED      = 32'd91385
) (
   input  logic                 clk_i,
   input  logic                 reset,
   input  logic [ADDR_W-1:0]    awaddr_i,
   input  logic                 awvalid_i,
   output logic                 awready_o,
   input  logic [BE_DATA_W-1:0] wdata_i,
   input  logic [BE_NBYTES-1:0] wstrb_i,
   input  logic                 wlast_i,
   input  logic                 wvalid_i,
   output logic                 wready_o,
   output logic                 bvalid_o,
   output logic [1:0]           bresp_o,
   input  logic                 bready_i
);

   localparam logic [1:0] PH_ADDR     = 2'd0;
   localparam logic [1:0] PH_DATA     = 2'd1;
   localparam logic [1:0] PH_RESP     = 2'd2;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic [7:0]        mem [MEM_BYTES];
   logic [1:0]        phase;
   logic [31:0]       rnd;
   int                txn_cnt;   // finished transactions including errors
   logic [ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]  beat_q;
   logic              fail_q;    // this transaction gets an error
   logic              w_commit;

   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin
      for (int a = 0; a < MEM_BYTES; a++) begin
         mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);  // every address bit shows up
      end
   end

   // an errored transaction leaves memory untouched
   assign w_commit = (phase == PH_DATA) && wvalid_i && wready_o && !fail_q;

   always @(posedge clk_i) begin
      int idx;
      if (w_commit) begin
         for (int i = 0; i < BE_NBYTES; i++) begin
            idx = (int'(addr_q) + int'(beat_q) * BE_NBYTES + i) % MEM_BYTES;
            if (wstrb_i[i]) begin
               mem[idx] <= wdata_i[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         phase     <= PH_ADDR;
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         bresp_o   <= RESP_OKAY;
         rnd       <= SEED;
         txn_cnt   <= 0;
         addr_q    <= '0;
         beat_q    <= '0;
         fail_q    <= 1'b0;
      end else begin
         rnd <= next_rand(rnd);
         case (phase)
            PH_ADDR: begin
               awready_o <= rnd[0] & rnd[1];  // ready one cycle in four
               if (awvalid_i && awready_o) begin
                  awready_o <= 1'b0;
                  addr_q    <= awaddr_i;
                  beat_q    <= '0;
                  fail_q    <= (txn_cnt % ERR_EVERY) == ERR_EVERY - 1;
                  phase     <= PH_DATA;
               end
            end
            PH_DATA: begin
               wready_o <= rnd[2] | rnd[3];
               if (wvalid_i && wready_o) begin
                  beat_q <= beat_q + 1'b1;
                  if (wlast_i) begin
                     wready_o <= 1'b0;
                     bvalid_o <= 1'b1;
                     bresp_o  <= fail_q ? RESP_SLVERR : RESP_OKAY;
                     phase    <= PH_RESP;
                  end
               end
            end
            default: begin
               if (bvalid_o && bready_i) begin
                  bvalid_o <= 1'b0;
                  txn_cnt  <= txn_cnt + 1;
                  phase    <= PH_ADDR;
               end
            end
         endcase
      end
   end

endmodule

// ==== tb_cache_wr_path.sv ====
`timescale 1ns/1ps

module tb_cache_wr_path
   import cache_wr_pkg::*;
();

   localparam int          BUF_DEPTH_W = 2;
   localparam int          AXI_LEN_W   = 8;
   localparam int          MEM_BYTES   = 1024;
   localparam int          TIMEOUT     = 2000;  // cycles allowed per wait
   localparam int          BURST_REQS  = 24;
   localparam logic [31:0] RAND_SEED   = 32'd91385;

   logic                 clk_i = 1'b0;
   logic                 reset;
   logic                 req_valid_i;
   logic                 req_kind_i;
   logic [ADDR_W-1:0]    req_addr_i;
   logic [LINE_W-1:0]    req_wdata_i;
   logic [NBYTES-1:0]    req_wstrb_i;
   logic                 req_ready_o;
   logic                 idle_o;
   logic [ADDR_W-1:0]    axi_awaddr_o;
   logic [AXI_LEN_W-1:0] axi_awlen_o;
   logic                 axi_awvalid_o;
   logic                 axi_awready_i;
   logic [BE_DATA_W-1:0] axi_wdata_o;
   logic [BE_NBYTES-1:0] axi_wstrb_o;
   logic                 axi_wlast_o;
   logic                 axi_wvalid_o;
   logic                 axi_wready_i;
   logic                 axi_bvalid_i;
   logic [1:0]           axi_bresp_i;
   logic                 axi_bready_o;

   logic [7:0]           ref_mem [MEM_BYTES];
   logic                 exp_kind [$];  // accepted and not yet answered OKAY
   logic [ADDR_W-1:0]    exp_addr [$];
   logic [LINE_W-1:0]    exp_data [$];
   logic [NBYTES-1:0]    exp_strb [$];
   int                   beat_idx = 0;
   int                   fail_cnt = 0;
   int                   timeout_cnt = 0;
   int                   err_resp_cnt = 0;
   logic                 full_seen = 1'b0;
   logic [31:0]          rng;

   always #10 clk_i = ~clk_i;

   cache_wr_path #(
      .BUF_DEPTH_W (BUF_DEPTH_W),
      .AXI_AW_LEN_W(AXI_LEN_W)
   ) cache_wr_path_i (
      .clk_i, .reset, .req_valid_i, .req_kind_i, .req_addr_i, .req_wdata_i, .req_wstrb_i,
      .req_ready_o, .idle_o, .axi_awaddr_o, .axi_awlen_o, .axi_awvalid_o, .axi_awready_i,
      .axi_wdata_o, .axi_wstrb_o, .axi_wlast_o, .axi_wvalid_o, .axi_wready_i,
      .axi_bvalid_i, .axi_bresp_i, .axi_bready_o
   );

   tb_axi_mem #(
      .MEM_BYTES(MEM_BYTES),
      .LEN_W    (AXI_LEN_W),
      .SEED     (RAND_SEED)
   ) axi_mem_i (
      .clk_i    (clk_i),
      .reset    (reset),
      .awaddr_i (axi_awaddr_o),
      .awvalid_i(axi_awvalid_o),
      .awready_o(axi_awready_i),
      .wdata_i  (axi_wdata_o),
      .wstrb_i  (axi_wstrb_o),
      .wlast_i  (axi_wlast_o),
      .wvalid_i (axi_wvalid_o),
      .wready_o (axi_wready_i),
      .bvalid_o (axi_bvalid_i),
      .bresp_o  (axi_bresp_i),
      .bready_i (axi_bready_o)
   );

   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [ADDR_W-1:0] exp_awaddr(input logic kind,
                                                    input logic [ADDR_W-1:0] addr);
      if (kind) begin
         return {addr[ADDR_W-1:4], 4'b0};  // line burst on 16 bytes
      end
      return {addr[ADDR_W-1:3], 3'b0};
   endfunction

   function automatic logic [BE_DATA_W-1:0] exp_wdata(input logic kind,
                                                      input logic [LINE_W-1:0] data,
                                                      input int beat);
      if (kind) begin
         return (beat == 0) ? data[63:0] : data[127:64];
      end
      return {data[31:0], data[31:0]};  // word in both halves
   endfunction

   function automatic logic [BE_NBYTES-1:0] exp_wstrb(input logic kind,
                                                      input logic [ADDR_W-1:0] addr,
                                                      input logic [NBYTES-1:0] strb);
      if (kind) begin
         return 8'hff;
      end
      return addr[2] ? {strb, 4'b0} : {4'b0, strb};
   endfunction

   task automatic note_failure(input string msg);
      fail_cnt++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic update_ref(input logic kind, input logic [ADDR_W-1:0] addr,
                             input logic [LINE_W-1:0] data, input logic [NBYTES-1:0] strb);
      int base;
      if (kind) begin
         base = int'(addr) & ~15;
         for (int i = 0; i < 16; i++) begin
            ref_mem[(base + i) % MEM_BYTES] = data[8*i +: 8];
         end
      end else begin
         base = int'(addr) & ~3;
         for (int i = 0; i < NBYTES; i++) begin
            if (strb[i]) begin
               ref_mem[(base + i) % MEM_BYTES] = data[8*i +: 8];
            end
         end
      end
   endtask

   // starts on the edge that accepts the previous request
   task automatic send_req(input logic kind, input logic [ADDR_W-1:0] addr,
                           input logic [LINE_W-1:0] data, input logic [NBYTES-1:0] strb);
      int waited;
      waited = 0;
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_kind_i  <= kind;
      req_addr_i  <= addr;
      req_wdata_i <= data;
      req_wstrb_i <= strb;
      @(negedge clk_i);
      while (!req_ready_o && waited < TIMEOUT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!req_ready_o) begin
         timeout_cnt++;
         $display("timeout: request not accepted within %0d cycles", TIMEOUT);
      end
   endtask

   task automatic send_random();
      logic [LINE_W-1:0] data;
      logic [31:0]       r;
      for (int i = 0; i < 4; i++) begin
         rng = next_rand(rng);
         data[32*i +: 32] = rng;
      end
      rng = next_rand(rng);
      r = rng;
      send_req(r[0], ADDR_W'(r[17:8]), data, r[31:28]);  // small window for many overlaps
   endtask

   task automatic end_reqs();
      @(posedge clk_i);
      req_valid_i <= 1'b0;
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      @(negedge clk_i);
      while (!idle_o && waited < TIMEOUT) begin
         @(negedge clk_i);
         waited++;
      end
      if (!idle_o) begin
         timeout_cnt++;
         $display("timeout: write path did not drain within %0d cycles", TIMEOUT);
      end
   endtask

   // handshakes seen here complete on the next rising edge
   always @(negedge clk_i) begin
      if (!reset) begin
         assert (!idle_o || exp_kind.size() == 0)
            else note_failure("idle_o high while writes are outstanding");
         if (!req_ready_o) begin
            full_seen = 1'b1;
         end
         if (axi_awvalid_o && axi_awready_i) begin
            assert (exp_kind.size() > 0)
               else note_failure("address phase without an accepted request");
            if (exp_kind.size() > 0) begin
               assert (axi_awaddr_o == exp_awaddr(exp_kind[0], exp_addr[0]))
                  else note_failure($sformatf("awaddr %h, expected %h", axi_awaddr_o,
                                              exp_awaddr(exp_kind[0], exp_addr[0])));
               assert (axi_awlen_o == AXI_LEN_W'(exp_kind[0]))
                  else note_failure($sformatf("awlen %0d for kind %0d", axi_awlen_o,
                                              exp_kind[0]));
            end
            beat_idx = 0;
         end
         if (axi_wvalid_o && axi_wready_i && exp_kind.size() > 0) begin
            assert (axi_wdata_o == exp_wdata(exp_kind[0], exp_data[0], beat_idx))
               else note_failure($sformatf("wdata %h on beat %0d, expected %h", axi_wdata_o,
                                           beat_idx, exp_wdata(exp_kind[0], exp_data[0],
                                                               beat_idx)));
            assert (axi_wstrb_o == exp_wstrb(exp_kind[0], exp_addr[0], exp_strb[0]))
               else note_failure($sformatf("wstrb %h, expected %h", axi_wstrb_o,
                                           exp_wstrb(exp_kind[0], exp_addr[0], exp_strb[0])));
            assert (axi_wlast_o == (!exp_kind[0] || beat_idx == 1))
               else note_failure($sformatf("wlast %0b on beat %0d", axi_wlast_o, beat_idx));
            beat_idx++;
         end
         if (axi_bvalid_i && axi_bready_o) begin
            if (axi_bresp_i != RESP_OKAY) begin
               err_resp_cnt++;  // same entry must come back
            end else if (exp_kind.size() > 0) begin
               void'(exp_kind.pop_front());
               void'(exp_addr.pop_front());
               void'(exp_data.pop_front());
               void'(exp_strb.pop_front());
            end
         end
         if (req_valid_i && req_ready_o) begin
            exp_kind.push_back(req_kind_i);
            exp_addr.push_back(req_addr_i);
            exp_data.push_back(req_wdata_i);
            exp_strb.push_back(req_wstrb_i);
            update_ref(req_kind_i, req_addr_i, req_wdata_i, req_wstrb_i);
         end
      end
   end

   initial begin
      reset       = 1'b1;
      req_valid_i = 1'b0;
      req_kind_i  = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_wstrb_i = '0;
      rng         = RAND_SEED;
      for (int a = 0; a < MEM_BYTES; a++) begin
         ref_mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);
      end
      repeat (10) @(posedge clk_i);
      reset <= 1'b0;

      @(negedge clk_i);
      assert (!axi_awvalid_o && !axi_wvalid_o && !axi_bready_o)
         else note_failure("AXI control outputs not low after reset");
      assert (req_ready_o && idle_o)
         else note_failure("req_ready_o or idle_o not high after reset");

      // awvalid two edges after the accepting edge
      send_random();
      end_reqs();
      @(negedge clk_i);
      assert (!axi_awvalid_o) else note_failure("awvalid high one edge after acceptance");
      @(negedge clk_i);
      assert (axi_awvalid_o) else note_failure("awvalid low two edges after acceptance");
      wait_idle();

      repeat (10) begin
         send_random();
         end_reqs();
         wait_idle();
      end

      repeat (BURST_REQS) send_random();  // back to back to fill the buffer
      end_reqs();
      wait_idle();

      assert (full_seen) else note_failure("req_ready_o never went low");
      assert (err_resp_cnt > 0) else note_failure("no error response was exercised");
      assert (exp_kind.size() == 0) else note_failure("accepted requests never completed");
      for (int a = 0; a < MEM_BYTES; a++) begin
         assert (axi_mem_i.mem[a] == ref_mem[a])
            else note_failure($sformatf("memory byte %0d is %h, expected %h", a,
                                        axi_mem_i.mem[a], ref_mem[a]));
      end

      $display("checks failed: %0d, timeouts: %0d, error responses: %0d",
               fail_cnt, timeout_cnt, err_resp_cnt);
      if (fail_cnt == 0 && timeout_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
cache_wr_pkg.sv
cache_wr_buffer.sv
axi_wr_beat_gen.sv
axi_wr_ctrl.sv
cache_wr_path.sv
tb_axi_mem.sv
tb_cache_wr_path.sv

// ==== Makefile ====
# Verilator build and run of the cache write-back path testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_wr_path
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
